//--- hdl/glb_pkg.sv
// global buffer tile package with widths, register map enum and dma state enum
package glb_pkg;

    // bank and stream word
    localparam int DATA_WIDTH = 16;
    // one strobe per byte
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    // word address, covers the deepest bank
    localparam int ADDR_WIDTH = 8;

    // register bus address
    localparam int CFG_ADDR_WIDTH = 3;

    // tile index on the interrupt chain
    localparam int TILE_ID_WIDTH = 3;

    // register map
    typedef enum logic [CFG_ADDR_WIDTH-1:0] {
        ST_BASE = 3'd0,
        ST_LEN  = 3'd1,
        ST_CTRL = 3'd2,
        LD_BASE = 3'd3,
        LD_LEN  = 3'd4,
        LD_CTRL = 3'd5,
        STATUS  = 3'd6
    } cfg_reg_e;

    // four-phase dma sequence
    typedef enum logic [1:0] {
        IDLE         = 2'd0,
        REQ          = 2'd1,
        WAIT_ACK_LOW = 2'd2,
        DONE         = 2'd3
    } dma_state_e;

endpackage

//--- hdl/glb_tile_cfg.sv
// configuration register file with dma control bits and registered read path
`timescale 1ns/1ps

module glb_tile_cfg
    import glb_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cfg_wr_en,
    input  logic                  cfg_rd_en,
    input  cfg_reg_e              cfg_addr,
    input  logic [DATA_WIDTH-1:0] cfg_wr_data,
    input  logic                  st_done,
    input  logic                  ld_done,
    output logic [DATA_WIDTH-1:0] cfg_rd_data,
    output logic [ADDR_WIDTH-1:0] st_base,
    output logic [ADDR_WIDTH-1:0] st_len,
    output logic [ADDR_WIDTH-1:0] ld_base,
    output logic [ADDR_WIDTH-1:0] ld_len,
    output logic                  st_on,
    output logic                  ld_on
);

    // register writes and done clears
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            st_base <= '0;
            st_len  <= '0;
            ld_base <= '0;
            ld_len  <= '0;
            st_on   <= 1'b0;
            ld_on   <= 1'b0;
        end else begin
            if (cfg_wr_en) begin
                case (cfg_addr)
                    ST_BASE: st_base <= cfg_wr_data[ADDR_WIDTH-1:0];
                    ST_LEN:  st_len  <= cfg_wr_data[ADDR_WIDTH-1:0];
                    LD_BASE: ld_base <= cfg_wr_data[ADDR_WIDTH-1:0];
                    LD_LEN:  ld_len  <= cfg_wr_data[ADDR_WIDTH-1:0];
                    // ctrl bit only takes effect when idle
                    ST_CTRL: if (!st_on) st_on <= cfg_wr_data[0];
                    LD_CTRL: if (!ld_on) ld_on <= cfg_wr_data[0];
                    default: ;
                endcase
            end
            // dma finished so drop its on bit
            if (st_done) begin
                st_on <= 1'b0;
            end
            if (ld_done) begin
                ld_on <= 1'b0;
            end
        end
    end

    // read data one cycle after cfg_rd_en
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_rd_data <= '0;
        end else if (cfg_rd_en) begin
            case (cfg_addr)
                ST_BASE: cfg_rd_data <= DATA_WIDTH'(st_base);
                ST_LEN:  cfg_rd_data <= DATA_WIDTH'(st_len);
                ST_CTRL: cfg_rd_data <= DATA_WIDTH'(st_on);
                LD_BASE: cfg_rd_data <= DATA_WIDTH'(ld_base);
                LD_LEN:  cfg_rd_data <= DATA_WIDTH'(ld_len);
                LD_CTRL: cfg_rd_data <= DATA_WIDTH'(ld_on);
                // busy bits, store in bit 0
                STATUS:  cfg_rd_data <= DATA_WIDTH'({ld_on, st_on});
                default: cfg_rd_data <= '0;
            endcase
        end
    end

endmodule

//--- hdl/glb_store_dma.sv
// store dma with f2g input fifo and four-phase bank write sequencer
`timescale 1ns/1ps

module glb_store_dma
    import glb_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  st_on,
    input  logic [ADDR_WIDTH-1:0] st_base,
    input  logic [ADDR_WIDTH-1:0] st_len,
    input  logic [DATA_WIDTH-1:0] stream_data_f2g,
    input  logic                  stream_data_valid_f2g,
    input  logic                  st_ack,
    output logic                  st_req,
    output logic [ADDR_WIDTH-1:0] st_addr,
    output logic [DATA_WIDTH-1:0] st_data,
    output logic                  st_done
);

    localparam int FIFO_DEPTH = 4;
    localparam int PTR_WIDTH  = $clog2(FIFO_DEPTH);

    dma_state_e            state;
    logic [DATA_WIDTH-1:0] fifo_mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]  fifo_wr_ptr;
    logic [PTR_WIDTH-1:0]  fifo_rd_ptr;
    logic [PTR_WIDTH:0]    fifo_cnt;
    // words taken from the stream, one more bit than st_len
    logic [ADDR_WIDTH:0]   acc_cnt;
    // index of the word being written
    logic [ADDR_WIDTH-1:0] wr_idx;
    logic                  push;
    logic                  pop;
    logic                  last_word;

    // accept only while armed and short of len+1 words
    assign push = st_on && stream_data_valid_f2g &&
                  (fifo_cnt != FIFO_DEPTH[PTR_WIDTH:0]) &&
                  (acc_cnt <= {1'b0, st_len});
    // word retires once ack has fallen
    assign pop       = (state == WAIT_ACK_LOW) && !st_ack;
    assign last_word = (wr_idx == st_len);

    // fifo storage
    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[fifo_wr_ptr] <= stream_data_f2g;
        end
    end

    // fifo pointers and word counters
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fifo_wr_ptr <= '0;
            fifo_rd_ptr <= '0;
            fifo_cnt    <= '0;
            acc_cnt     <= '0;
        end else begin
            if (push) begin
                fifo_wr_ptr <= fifo_wr_ptr + 1'b1;
            end
            if (pop) begin
                fifo_rd_ptr <= fifo_rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: ;
            endcase
            // restart the count for the next transfer
            if (state == DONE) begin
                acc_cnt <= '0;
            end else if (push) begin
                acc_cnt <= acc_cnt + 1'b1;
            end
        end
    end

    // four-phase write sequence
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= IDLE;
            wr_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (fifo_cnt != '0) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (st_ack) begin
                        state <= WAIT_ACK_LOW;
                    end
                end
                WAIT_ACK_LOW: begin
                    if (!st_ack) begin
                        state  <= last_word ? DONE : IDLE;
                        wr_idx <= wr_idx + 1'b1;
                    end
                end
                DONE: begin
                    state  <= IDLE;
                    wr_idx <= '0;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // head of fifo stays put until pop
    assign st_req  = (state == REQ);
    assign st_addr = st_base + wr_idx;
    assign st_data = fifo_mem[fifo_rd_ptr];
    assign st_done = (state == DONE);

endmodule

//--- hdl/glb_bank.sv
// single-port sram bank with strobed host writes and host/store/load arbiter
`timescale 1ns/1ps

module glb_bank
    import glb_pkg::*;
#(
    parameter int BANK_WORDS = 64
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic [STRB_WIDTH-1:0] wr_strb,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  logic [DATA_WIDTH-1:0] wr_data,
    input  logic                  rd_en,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    input  logic                  st_req,
    input  logic [ADDR_WIDTH-1:0] st_addr,
    input  logic [DATA_WIDTH-1:0] st_data,
    input  logic                  ld_req,
    input  logic [ADDR_WIDTH-1:0] ld_addr,
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic                  st_ack,
    output logic                  ld_ack,
    output logic [DATA_WIDTH-1:0] ld_data
);

    localparam int IDX_WIDTH = $clog2(BANK_WORDS);

    logic [DATA_WIDTH-1:0] mem [BANK_WORDS];
    logic [IDX_WIDTH-1:0]  wr_idx;
    logic [IDX_WIDTH-1:0]  rd_idx;
    logic [IDX_WIDTH-1:0]  st_idx;
    logic [IDX_WIDTH-1:0]  ld_idx;
    logic                  host_busy;
    logic                  st_grant;
    logic                  ld_grant;

    // addresses wrap at the bank depth
    function automatic logic [IDX_WIDTH-1:0] wrap_idx(input logic [ADDR_WIDTH-1:0] addr);
        return IDX_WIDTH'(addr % BANK_WORDS);
    endfunction

    assign wr_idx = wrap_idx(wr_addr);
    assign rd_idx = wrap_idx(rd_addr);
    assign st_idx = wrap_idx(st_addr);
    assign ld_idx = wrap_idx(ld_addr);

    // fixed priority host then store then load
    assign host_busy = wr_en || rd_en;
    // new request only while ack is still low
    assign st_grant  = st_req && !st_ack && !host_busy;
    assign ld_grant  = ld_req && !ld_ack && !host_busy && !st_grant;

    // array write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end else if (st_grant) begin
            // dma writes full words
            mem[st_idx] <= st_data;
        end
    end

    // read data registers
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
        // held for the whole ack high phase
        if (ld_grant) begin
            ld_data <= mem[ld_idx];
        end
    end

    // ack side of both handshakes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            st_ack <= 1'b0;
            ld_ack <= 1'b0;
        end else begin
            if (st_grant) begin
                st_ack <= 1'b1;
            end else if (!st_req) begin
                st_ack <= 1'b0;
            end
            if (ld_grant) begin
                ld_ack <= 1'b1;
            end else if (!ld_req) begin
                ld_ack <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/glb_load_dma.sv
// load dma with four-phase bank read sequencer and g2f stream output
`timescale 1ns/1ps

module glb_load_dma
    import glb_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ld_on,
    input  logic [ADDR_WIDTH-1:0] ld_base,
    input  logic [ADDR_WIDTH-1:0] ld_len,
    input  logic                  ld_ack,
    input  logic [DATA_WIDTH-1:0] ld_data,
    output logic                  ld_req,
    output logic [ADDR_WIDTH-1:0] ld_addr,
    output logic [DATA_WIDTH-1:0] stream_data_g2f,
    output logic                  stream_data_valid_g2f,
    output logic                  ld_done
);

    dma_state_e            state;
    // index of the word being read
    logic [ADDR_WIDTH-1:0] rd_idx;
    logic                  beat;

    // first cycle of ack high while still requesting
    assign beat = (state == REQ) && ld_ack;

    // read sequence over len+1 words
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= IDLE;
            rd_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (ld_on) begin
                        state  <= REQ;
                        rd_idx <= '0;
                    end
                end
                REQ: begin
                    if (ld_ack) begin
                        state <= WAIT_ACK_LOW;
                    end
                end
                WAIT_ACK_LOW: begin
                    // next word goes straight back to req
                    if (!ld_ack) begin
                        if (rd_idx == ld_len) begin
                            state <= DONE;
                        end else begin
                            state  <= REQ;
                            rd_idx <= rd_idx + 1'b1;
                        end
                    end
                end
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // one stream beat per acked word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stream_data_valid_g2f <= 1'b0;
        end else begin
            stream_data_valid_g2f <= beat;
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            stream_data_g2f <= ld_data;
        end
    end

    assign ld_req  = (state == REQ);
    assign ld_addr = ld_base + rd_idx;
    assign ld_done = (state == DONE);

endmodule

//--- hdl/glb_tile.sv
// global buffer tile top with cfg, store dma, bank, load dma and interrupt chain
`timescale 1ns/1ps

module glb_tile
    import glb_pkg::*;
#(
    parameter int BANK_WORDS = 64,
    parameter int NUM_TILES  = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [TILE_ID_WIDTH-1:0] glb_tile_id,

    // host port
    input  logic                     wr_en,
    input  logic [STRB_WIDTH-1:0]    wr_strb,
    input  logic [ADDR_WIDTH-1:0]    wr_addr,
    input  logic [DATA_WIDTH-1:0]    wr_data,
    input  logic                     rd_en,
    input  logic [ADDR_WIDTH-1:0]    rd_addr,
    output logic [DATA_WIDTH-1:0]    rd_data,

    // register bus
    input  logic                     cfg_wr_en,
    input  logic                     cfg_rd_en,
    input  cfg_reg_e                 cfg_addr,
    input  logic [DATA_WIDTH-1:0]    cfg_wr_data,
    output logic [DATA_WIDTH-1:0]    cfg_rd_data,

    // fabric streams
    input  logic [DATA_WIDTH-1:0]    stream_data_f2g,
    input  logic                     stream_data_valid_f2g,
    output logic [DATA_WIDTH-1:0]    stream_data_g2f,
    output logic                     stream_data_valid_g2f,

    // interrupt daisy chain
    input  logic [2*NUM_TILES-1:0]   interrupt_pulse_wsti,
    output logic [2*NUM_TILES-1:0]   interrupt_pulse_esto
);

    // dma programming
    logic [ADDR_WIDTH-1:0]  st_base;
    logic [ADDR_WIDTH-1:0]  st_len;
    logic [ADDR_WIDTH-1:0]  ld_base;
    logic [ADDR_WIDTH-1:0]  ld_len;
    logic                   st_on;
    logic                   ld_on;

    // store handshake
    logic                   st_req;
    logic [ADDR_WIDTH-1:0]  st_addr;
    logic [DATA_WIDTH-1:0]  st_data;
    logic                   st_ack;
    logic                   st_done;

    // load handshake
    logic                   ld_req;
    logic [ADDR_WIDTH-1:0]  ld_addr;
    logic                   ld_ack;
    logic [DATA_WIDTH-1:0]  ld_data;
    logic                   ld_done;

    logic [2*NUM_TILES-1:0] interrupt_next;

    glb_tile_cfg glb_tile_cfg_i (
        .clk         (clk),
        .reset       (reset),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_rd_en   (cfg_rd_en),
        .cfg_addr    (cfg_addr),
        .cfg_wr_data (cfg_wr_data),
        .st_done     (st_done),
        .ld_done     (ld_done),
        .cfg_rd_data (cfg_rd_data),
        .st_base     (st_base),
        .st_len      (st_len),
        .ld_base     (ld_base),
        .ld_len      (ld_len),
        .st_on       (st_on),
        .ld_on       (ld_on)
    );

    glb_store_dma glb_store_dma_i (
        .clk                   (clk),
        .reset                 (reset),
        .st_on                 (st_on),
        .st_base               (st_base),
        .st_len                (st_len),
        .stream_data_f2g       (stream_data_f2g),
        .stream_data_valid_f2g (stream_data_valid_f2g),
        .st_ack                (st_ack),
        .st_req                (st_req),
        .st_addr               (st_addr),
        .st_data               (st_data),
        .st_done               (st_done)
    );

    glb_bank #(
        .BANK_WORDS (BANK_WORDS)
    ) glb_bank_i (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_strb (wr_strb),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .st_req  (st_req),
        .st_addr (st_addr),
        .st_data (st_data),
        .ld_req  (ld_req),
        .ld_addr (ld_addr),
        .rd_data (rd_data),
        .st_ack  (st_ack),
        .ld_ack  (ld_ack),
        .ld_data (ld_data)
    );

    glb_load_dma glb_load_dma_i (
        .clk                   (clk),
        .reset                 (reset),
        .ld_on                 (ld_on),
        .ld_base               (ld_base),
        .ld_len                (ld_len),
        .ld_ack                (ld_ack),
        .ld_data               (ld_data),
        .ld_req                (ld_req),
        .ld_addr               (ld_addr),
        .stream_data_g2f       (stream_data_g2f),
        .stream_data_valid_g2f (stream_data_valid_g2f),
        .ld_done               (ld_done)
    );

    // pass the chain through and replace this tile's pair
    always_comb begin
        interrupt_next                    = interrupt_pulse_wsti;
        interrupt_next[2*glb_tile_id]     = st_done;
        interrupt_next[2*glb_tile_id + 1] = ld_done;
    end

    // one register stage per tile
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            interrupt_pulse_esto <= '0;
        end else begin
            interrupt_pulse_esto <= interrupt_next;
        end
    end

endmodule

//--- tests/glb_tile_tests.svh
// tile test tasks with bus drivers, scoreboard update, f2g sender and the directed tests

// everything idle with reset held
task automatic init_inputs();
    clk                   = 1'b0;
    reset                 = 1'b1;
    glb_tile_id           = TILE_ID_WIDTH'(TILE_ID);
    wr_en                 = 1'b0;
    wr_strb               = '0;
    wr_addr               = '0;
    wr_data               = '0;
    rd_en                 = 1'b0;
    rd_addr               = '0;
    cfg_wr_en             = 1'b0;
    cfg_rd_en             = 1'b0;
    cfg_addr              = ST_BASE;
    cfg_wr_data           = '0;
    stream_data_f2g       = '0;
    stream_data_valid_f2g = 1'b0;
    interrupt_pulse_wsti  = '0;
    st_pulse_cycles       = 0;
    ld_pulse_cycles       = 0;
    late_beats            = 0;
    error_count           = 0;
    cycle_cnt             = 0;
    seed                  = 32'he949bfa8;
endtask

// inputs change 2 ns after the rising edge
task automatic step();
    @(posedge clk);
    #2;
endtask

task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
        error_count++;
        $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
        $display("** FAIL **");
        $fatal(1, "check failed");
    end
endtask

// one cycle host write, scoreboard takes only strobed bytes
task automatic host_write(input logic [ADDR_WIDTH-1:0] addr,
                          input logic [STRB_WIDTH-1:0] strb,
                          input logic [DATA_WIDTH-1:0] data);
    int idx;
    int b;
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_strb = strb;
    wr_data = data;
    step();
    wr_en   = 1'b0;
    idx = int'(addr) % BANK_WORDS;
    for (b = 0; b < STRB_WIDTH; b++) begin
        if (strb[b]) begin
            model[idx][8*b +: 8] = data[8*b +: 8];
        end
    end
endtask

// data is back one cycle after rd_en
task automatic host_read_check(input logic [ADDR_WIDTH-1:0] addr,
                               input logic [DATA_WIDTH-1:0] exp, input string what);
    rd_en   = 1'b1;
    rd_addr = addr;
    step();
    rd_en   = 1'b0;
    check_equal(32'(rd_data), 32'(exp), what);
endtask

task automatic cfg_write(input cfg_reg_e addr, input logic [DATA_WIDTH-1:0] data);
    cfg_wr_en   = 1'b1;
    cfg_addr    = addr;
    cfg_wr_data = data;
    step();
    cfg_wr_en   = 1'b0;
endtask

task automatic cfg_read_check(input cfg_reg_e addr, input logic [DATA_WIDTH-1:0] exp,
                              input string what);
    cfg_rd_en = 1'b1;
    cfg_addr  = addr;
    step();
    cfg_rd_en = 1'b0;
    check_equal(32'(cfg_rd_data), 32'(exp), what);
endtask

// single f2g word, then the minimum gap
task automatic send_f2g(input logic [DATA_WIDTH-1:0] data);
    stream_data_f2g       = data;
    stream_data_valid_f2g = 1'b1;
    step();
    wait_f2g_gap();
endtask

task automatic wait_f2g_gap();
    stream_data_valid_f2g = 1'b0;
    repeat (F2G_GAP-1) step();
endtask

task automatic reset_state_test();
    $display("reset state test");
    check_equal(32'(interrupt_pulse_esto), 32'h0, "interrupt after reset");
    check_equal(32'(stream_data_valid_g2f), 32'h0, "g2f valid after reset");
    cfg_read_check(STATUS, '0, "status after reset");
endtask

task automatic host_access_test();
    int a;
    int i;
    logic [ADDR_WIDTH-1:0] addr;
    $display("host access test");
    // full words first so no byte stays unknown
    for (a = 0; a < BANK_WORDS; a++) begin
        host_write(ADDR_WIDTH'(a), '1, DATA_WIDTH'($random(seed)));
    end
    // partial writes, strobe 0 included
    for (i = 0; i < 32; i++) begin
        addr = ADDR_WIDTH'($unsigned($random(seed)) % BANK_WORDS);
        host_write(addr, STRB_WIDTH'($random(seed)), DATA_WIDTH'($random(seed)));
    end
    for (a = 0; a < BANK_WORDS; a++) begin
        host_read_check(ADDR_WIDTH'(a), model[a], "host read");
    end
endtask

task automatic cfg_register_test();
    cfg_reg_e              regs [4] = '{ST_BASE, ST_LEN, LD_BASE, LD_LEN};
    logic [ADDR_WIDTH-1:0] vals [4];
    int                    r;
    $display("register test");
    for (r = 0; r < 4; r++) begin
        vals[r] = ADDR_WIDTH'($random(seed));
        cfg_write(regs[r], DATA_WIDTH'(vals[r]));
    end
    for (r = 0; r < 4; r++) begin
        cfg_read_check(regs[r], DATA_WIDTH'(vals[r]), "register readback");
    end
endtask

task automatic store_dma_test();
    logic [ADDR_WIDTH-1:0] base;
    logic [DATA_WIDTH-1:0] sent [ST_WORDS];
    int                    i;
    int                    idx;
    $display("store dma test");
    // base near the top so the region wraps
    base = ADDR_WIDTH'(BANK_WORDS - ST_WORDS) + ADDR_WIDTH'($unsigned($random(seed)) % ST_WORDS);
    st_pulse_cycles = 0;
    cfg_write(ST_BASE, DATA_WIDTH'(base));
    cfg_write(ST_LEN, DATA_WIDTH'(ST_WORDS-1));
    cfg_write(ST_CTRL, 16'h0001);
    for (i = 0; i < ST_WORDS; i++) begin
        sent[i] = DATA_WIDTH'($random(seed));
        send_f2g(sent[i]);
    end
    // end of transfer is bit 4 of the chain
    while (st_pulse_cycles == 0) begin
        step();
    end
    repeat (3) step();
    check_equal(32'(st_pulse_cycles), 32'd1, "store interrupt cycles");
    for (i = 0; i < ST_WORDS; i++) begin
        idx = (int'(base) + i) % BANK_WORDS;
        model[idx] = sent[i];
        host_read_check(ADDR_WIDTH'(idx), sent[i], "stored word");
    end
    cfg_read_check(STATUS, '0, "status after store");
endtask

task automatic load_dma_test();
    logic [ADDR_WIDTH-1:0] base;
    logic [ADDR_WIDTH-1:0] len;
    int                    i;
    int                    idx;
    $display("load dma test");
    base = ADDR_WIDTH'($unsigned($random(seed)) % BANK_WORDS);
    len  = ADDR_WIDTH'(4 + $unsigned($random(seed)) % 8);
    for (i = 0; i <= int'(len); i++) begin
        idx = (int'(base) + i) % BANK_WORDS;
        host_write(ADDR_WIDTH'(idx), '1, DATA_WIDTH'($random(seed)));
    end
    g2f_beats.delete();
    ld_pulse_cycles = 0;
    late_beats      = 0;
    cfg_write(LD_BASE, DATA_WIDTH'(base));
    cfg_write(LD_LEN, DATA_WIDTH'(len));
    cfg_write(LD_CTRL, 16'h0001);
    while (ld_pulse_cycles == 0) begin
        step();
    end
    // quiet window to catch stray beats
    repeat (8) step();
    check_equal(32'(ld_pulse_cycles), 32'd1, "load interrupt cycles");
    check_equal(32'(late_beats), 32'd0, "beats after load interrupt");
    check_equal(32'(g2f_beats.size()), 32'(int'(len) + 1), "g2f beat count");
    for (i = 0; i < g2f_beats.size(); i++) begin
        idx = (int'(base) + i) % BANK_WORDS;
        check_equal(32'(g2f_beats[i]), 32'(model[idx]), "g2f word");
    end
    cfg_read_check(STATUS, '0, "status after load");
endtask

// idle tile passes the chain with its own pair at zero
task automatic interrupt_chain_test();
    logic [CHAIN_WIDTH-1:0] prev;
    logic [CHAIN_WIDTH-1:0] exp;
    int                     i;
    $display("interrupt chain test");
    prev = CHAIN_WIDTH'($random(seed));
    interrupt_pulse_wsti = prev;
    for (i = 0; i < 20; i++) begin
        step();
        exp = prev;
        exp[2*TILE_ID]   = 1'b0;
        exp[2*TILE_ID+1] = 1'b0;
        check_equal(32'(interrupt_pulse_esto), 32'(exp), "interrupt chain");
        prev = CHAIN_WIDTH'($random(seed));
        interrupt_pulse_wsti = prev;
    end
    step();
    interrupt_pulse_wsti = '0;
endtask

//--- tests/glb_tile_tb.sv
// tile testbench with clock, reset, dut instance, timeout, stream monitor and test sequence
`timescale 1ns/1ps

module glb_tile_tb
    import glb_pkg::*;
();

    localparam int BANK_WORDS     = 64;
    localparam int NUM_TILES      = 4;
    localparam int TILE_ID        = 2;
    localparam int CHAIN_WIDTH    = 2*NUM_TILES;
    // well above the length of all tests
    localparam int TIMEOUT_CYCLES = 3000;
    // store transfer size and f2g word spacing
    localparam int ST_WORDS       = 8;
    localparam int F2G_GAP        = 6;

    logic                     clk;
    logic                     reset;
    logic [TILE_ID_WIDTH-1:0] glb_tile_id;

    // host port
    logic                     wr_en;
    logic [STRB_WIDTH-1:0]    wr_strb;
    logic [ADDR_WIDTH-1:0]    wr_addr;
    logic [DATA_WIDTH-1:0]    wr_data;
    logic                     rd_en;
    logic [ADDR_WIDTH-1:0]    rd_addr;
    logic [DATA_WIDTH-1:0]    rd_data;

    // register bus
    logic                     cfg_wr_en;
    logic                     cfg_rd_en;
    cfg_reg_e                 cfg_addr;
    logic [DATA_WIDTH-1:0]    cfg_wr_data;
    logic [DATA_WIDTH-1:0]    cfg_rd_data;

    // fabric streams and interrupt chain
    logic [DATA_WIDTH-1:0]    stream_data_f2g;
    logic                     stream_data_valid_f2g;
    logic [DATA_WIDTH-1:0]    stream_data_g2f;
    logic                     stream_data_valid_g2f;
    logic [CHAIN_WIDTH-1:0]   interrupt_pulse_wsti;
    logic [CHAIN_WIDTH-1:0]   interrupt_pulse_esto;

    // scoreboard copy of the bank
    logic [DATA_WIDTH-1:0]    model [BANK_WORDS];
    // g2f words in arrival order
    logic [DATA_WIDTH-1:0]    g2f_beats [$];
    int                       st_pulse_cycles;
    int                       ld_pulse_cycles;
    // beats seen after the load interrupt
    int                       late_beats;
    int                       error_count;
    int                       cycle_cnt;
    integer                   seed;

    glb_tile #(
        .BANK_WORDS (BANK_WORDS),
        .NUM_TILES  (NUM_TILES)
    ) glb_tile_i (
        .clk                   (clk),
        .reset                 (reset),
        .glb_tile_id           (glb_tile_id),
        .wr_en                 (wr_en),
        .wr_strb               (wr_strb),
        .wr_addr               (wr_addr),
        .wr_data               (wr_data),
        .rd_en                 (rd_en),
        .rd_addr               (rd_addr),
        .rd_data               (rd_data),
        .cfg_wr_en             (cfg_wr_en),
        .cfg_rd_en             (cfg_rd_en),
        .cfg_addr              (cfg_addr),
        .cfg_wr_data           (cfg_wr_data),
        .cfg_rd_data           (cfg_rd_data),
        .stream_data_f2g       (stream_data_f2g),
        .stream_data_valid_f2g (stream_data_valid_f2g),
        .stream_data_g2f       (stream_data_g2f),
        .stream_data_valid_g2f (stream_data_valid_g2f),
        .interrupt_pulse_wsti  (interrupt_pulse_wsti),
        .interrupt_pulse_esto  (interrupt_pulse_esto)
    );

    // 20 ns period
    always #10 clk = ~clk;

    `include "glb_tile_tests.svh"

    // run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a transfer never finished", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1, "run stopped on timeout");
        end
    end

    // sample outputs mid cycle, away from the clock edge
    always @(negedge clk) begin
        if (!reset) begin
            if (stream_data_valid_g2f) begin
                g2f_beats.push_back(stream_data_g2f);
                if (ld_pulse_cycles != 0) begin
                    late_beats++;
                end
            end
            // count high cycles of this tile's pair
            if (interrupt_pulse_esto[2*TILE_ID]) begin
                st_pulse_cycles++;
            end
            if (interrupt_pulse_esto[2*TILE_ID+1]) begin
                ld_pulse_cycles++;
            end
        end
    end

    initial begin
        init_inputs();
        // reset for 4 cycles
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        step();
        reset_state_test();
        host_access_test();
        cfg_register_test();
        store_dma_test();
        load_dma_test();
        interrupt_chain_test();
        repeat (4) step();
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+tests
hdl/glb_pkg.sv
hdl/glb_tile_cfg.sv
hdl/glb_store_dma.sv
hdl/glb_bank.sv
hdl/glb_load_dma.sv
hdl/glb_tile.sv
tests/glb_tile_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the tile testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module glb_tile_tb -f src.f \
    || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/Vglb_tile_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '** PASS **' \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
